// ==== list.f ====
src/asg_pkg.sv
src/asg_regs.sv
src/asg_buffer.sv
src/asg_core.sv
src/asg_linear.sv
src/asg_top.sv
verification/asg_checker.sv
verification/asg_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the generator testbench with verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal or an assertion
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module asg_tb \
    -f list.f -o asg_sim &&
  ./obj_dir/asg_sim ||
  exit 1

// ==== verification/asg_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the arbitrary signal generator
// register and table access, continuous and burst playback,
// gain/offset rows, back-pressure on the sample stream
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_tb
  import asg_pkg::*;
();

  localparam int   n_smp  = 40;                       // samples per playback run
  localparam int   n_tbl  = 16;                       // table entries in use
  localparam int   n_lin  = 9;
  localparam int   n_rt   = 11;
  localparam int   n_bst  = 12;                       // two periods of 4 + 2
  localparam ptr_t p_one  = ptr_t'(1 << cwf);         // 1.0
  localparam ptr_t p_half = ptr_t'(1 << (cwf - 1));   // 0.5
  localparam ptr_t siz_16 = ptr_t'(n_tbl << cwf);
  localparam ptr_t off_2  = ptr_t'(2 << cwf);         // burst phase
  localparam sample_t bst_sum = -14'sd50;
  // 20 cycles for each table word, sample and bus word plus margin
  localparam int   wd_cycles =
    20 * (3 * n_tbl + 4 * n_smp + n_bst + 8 * n_lin + 2 * n_rt) + 4000;

  ////////////////////////////////////////////////////////////////////
  // stimulus tables
  ////////////////////////////////////////////////////////////////////

  // register offset, written word, read back masked to width
  localparam logic [bw-1:0] rt_adr [n_rt] = '{32'(reg_trg), 32'(reg_siz), 32'(reg_off),
    32'(reg_stp), 32'(reg_bst), 32'(reg_bdl), 32'(reg_bln), 32'(reg_bnm), 32'(reg_mul),
    32'(reg_sum), 32'h0000_0008};
  localparam logic [bw-1:0] rt_wr [n_rt] = '{32'hffff_ffff, 32'hffff_ffff, 32'h1234_5678,
    32'habcd_ef01, 32'hffff_ffff, 32'h0000_ffff, 32'hdead_beef, 32'h1234_5678,
    32'hffff_3abc, 32'h0000_5555, 32'hffff_ffff};
  localparam logic [bw-1:0] rt_rd [n_rt] = '{32'h0000_000f, 32'h03ff_ffff, 32'h0234_5678,
    32'h03cd_ef01, 32'h0000_0003, 32'h0000_03ff, 32'hdead_beef, 32'h0000_5678,
    32'h0000_3abc, 32'h0000_1555, 32'h0000_0000};

  // sample, gain (1.0 = 0x1000), offset, expected output
  localparam sample_t lx [n_lin] = '{14'sd1000, 14'sd1000, -14'sd1000, 14'sd8000,
    -14'sd8000, 14'sd5000, 14'sd100, -14'sd3, 14'sd4096};
  localparam sample_t lk [n_lin] = '{14'sh1000, 14'sh0800, 14'sh1000, 14'sh1000,
    14'sh1000, 14'sh1800, 14'sh3000, 14'sh0800, 14'sh2000};
  localparam sample_t lo [n_lin] = '{14'sd0, 14'sd10, -14'sd24, 14'sd500,
    -14'sd500, 14'sd1000, 14'sd0, 14'sd0, -14'sd1};
  localparam sample_t le [n_lin] = '{14'sd1000, 14'sd510, -14'sd1024, 14'sd8191,
    14'sh2000, 14'sd8191, -14'sd100, -14'sd2, 14'sh2000};

  logic          bus;
  logic          rst_n;
  logic          cyc;
  logic          stb;
  logic          we;
  logic [bw-1:0] adr;
  logic [bw-1:0] dat_w;
  logic [bw-1:0] dat_r;
  logic          ack;
  logic [tn-1:0] trg_ext;
  logic          trg_swo;
  logic          trg_out;
  logic          irq_trg;
  logic          irq_stp;
  logic          out_valid;
  sample_t       out_data;
  logic          out_last;
  logic          out_ready;

  sample_t tbl [0:(1<<cwm)-1];  // shadow of the waveform table
  sample_t got_d [$];           // accepted samples
  logic    got_l [$];
  int      swo_cnt = 0;         // pulse counters
  int      trg_cnt = 0;
  int      irq_cnt = 0;
  int      stp_cnt = 0;

  asg_top asg_top_inst (
    .bus, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .trg_ext, .trg_swo, .trg_out, .irq_trg, .irq_stp,
    .out_valid, .out_data, .out_last, .out_ready
  );

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;  // 50 MHz
  end

  always @(posedge bus) begin
    if (trg_swo) swo_cnt <= swo_cnt + 1;
    if (trg_out) trg_cnt <= trg_cnt + 1;
    if (irq_trg) irq_cnt <= irq_cnt + 1;
    if (irq_stp) stp_cnt <= stp_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic abort(string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(string name, logic [bw-1:0] got, logic [bw-1:0] exp);
    if (got !== exp) abort($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_sample(string name, sample_t got, sample_t exp);
    if (got !== exp) abort($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) abort($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // gain, >>> 12 (floor), offset, clip to 14 bits
  function automatic sample_t lin_ref(sample_t x, sample_t k, sample_t o);
    int v;
    v = (int'(x) * int'(k)) >>> mul_shift;
    v = v + int'(o);
    if (v > 8191) v = 8191;
    else if (v < -8192) v = -8192;
    return sample_t'(v);
  endfunction

  // pointer model adds the step and subtracts the size once on reaching it
  function automatic ptr_t ptr_step(ptr_t p, ptr_t stp, ptr_t siz);
    ptr_t n;
    n = p + stp;
    return (n >= siz) ? n - siz : n;
  endfunction

  function automatic logic [bw-1:0] tbl_adr(int i);
    return {19'h0, 1'b1, 10'(i), 2'b00};  // table region at 0x1000
  endfunction

  task automatic do_reset();
    rst_n = 1'b0;
    repeat (5) @(negedge bus);
    rst_n = 1'b1;
  endtask

  // starts and ends on a falling edge and holds stb through the ack cycle
  task automatic wb_xfer(logic w, logic [bw-1:0] a, logic [bw-1:0] d,
                         output logic [bw-1:0] q);
    int n;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_w = d;
    n     = 0;
    do begin
      @(negedge bus);
      n++;
      if (n > 8) abort("no wishbone ack within 8 cycles");
    end while (!ack);
    q = dat_r;  // valid with ack
    @(negedge bus);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(logic [bw-1:0] a, logic [bw-1:0] d);
    logic [bw-1:0] unused_q;
    wb_xfer(1'b1, a, d, unused_q);
  endtask

  task automatic wb_read(logic [bw-1:0] a, output logic [bw-1:0] q);
    wb_xfer(1'b0, a, '0, q);
  endtask

  // gather n accepted samples with optional random out_ready
  task automatic collect(int n, logic bp);
    int waited;
    waited = 0;
    got_d.delete();
    got_l.delete();
    while (got_d.size() < n) begin
      @(negedge bus);
      out_ready = bp ? 1'($urandom_range(1, 0)) : 1'b1;
      if (out_valid && out_ready) begin  // taken on the next rising edge
        got_d.push_back(out_data);
        got_l.push_back(out_last);
      end
      waited++;
      if (waited > 20 * n + 20) abort("sample stream stopped before enough samples arrived");
    end
  endtask

  task automatic expect_quiet(int n, string what);
    repeat (n) begin
      @(negedge bus);
      check_bit(what, out_valid, 1'b0);
    end
  endtask

  // generator reset, then drain the stream
  task automatic stop_gen();
    out_ready = 1'b1;
    wb_write(32'(reg_ctl), 32'h1);
    repeat (3) @(negedge bus);
    check_bit("out_valid after stop", out_valid, 1'b0);
  endtask

  // continuous run from phase 0 against the pointer model
  task automatic play_cont(ptr_t stp, logic bp);
    ptr_t p;
    ptr_t pn;
    int   s0;
    int   t0;
    int   i0;
    int   i;
    s0 = swo_cnt;
    t0 = trg_cnt;
    i0 = irq_cnt;
    wb_write(32'(reg_stp), 32'(stp));
    wb_write(32'(reg_ctl), 32'h2);  // software trigger
    collect(n_smp, bp);
    stop_gen();
    check_word("trg_swo pulses", swo_cnt - s0, 1);
    check_word("trg_out pulses", trg_cnt - t0, 1);
    check_word("irq_trg pulses", irq_cnt - i0, 1);
    p = '0;
    for (i = 0; i < n_smp; i++) begin
      pn = ptr_step(p, stp, siz_16);
      check_sample("out_data", got_d[i], lin_ref(tbl[p[cw-1:cwf]], mul_one, 14'sd0));
      check_bit("out_last", got_l[i], pn < p);  // pointer falls back at the period end
      p = pn;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [bw-1:0]          w;
    logic [bw-1:0]          e;
    logic [buf_sel_bit-1:0] roff;
    int                     i;
    int                     j;
    int                     per;
    int                     t0;
    int                     s0;
    ptr_t                   p;
    sample_t                exp_d;
    void'($urandom(65));
    rst_n     = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    trg_ext   = '0;
    out_ready = 1'b1;
    do_reset();
    check_word("outputs after reset",
               32'({ack, out_valid, out_last, trg_swo, trg_out, irq_trg, irq_stp}), 32'h0);

    // register window after reset, then the write/read table
    for (i = 0; i < 16; i++) begin
      roff = buf_sel_bit'(4 * i);
      e = (roff == reg_ctl) ? 32'h2 : (roff == reg_mul) ? 32'h1000 : 32'h0;
      wb_read(32'(roff), w);
      check_word($sformatf("reg 0x%0h after reset", roff), w, e);
    end
    for (i = 0; i < n_rt; i++) begin
      wb_write(rt_adr[i], rt_wr[i]);
      wb_read(rt_adr[i], w);
      check_word($sformatf("reg 0x%0h", rt_adr[i]), w, rt_rd[i]);
    end
    do_reset();  // back to default config

    // random table with junk in the upper word bits
    for (i = 0; i < n_tbl; i++) begin
      w = $urandom;
      tbl[i] = w[dw-1:0];
      wb_write(tbl_adr(i), w);
    end
    for (i = 0; i < n_tbl; i++) begin
      wb_read(tbl_adr(i), w);
      check_word($sformatf("table entry %0d", i), w, 32'(tbl[i]));
    end

    // continuous playback, then again under back-pressure
    wb_write(32'(reg_siz), 32'(siz_16));
    play_cont(p_one, 1'b0);
    play_cont(p_half, 1'b0);
    play_cont(p_one, 1'b1);
    play_cont(p_half, 1'b1);

    // gain and offset on a one entry table held by step 0
    wb_write(32'(reg_siz), 32'(p_one));
    wb_write(32'(reg_stp), 32'h0);
    for (i = 0; i < n_lin; i++) begin
      wb_write(tbl_adr(0), 32'(lx[i]));
      tbl[0] = lx[i];
      wb_write(32'(reg_mul), 32'(lk[i]));
      wb_write(32'(reg_sum), 32'(lo[i]));
      wb_write(32'(reg_ctl), 32'h2);
      collect(1, 1'b0);
      stop_gen();
      check_sample($sformatf("out_data row %0d", i), got_d[0], le[i]);
    end

    ////////////////////////////////////////////////////////////////////
    // burst with external triggers
    ////////////////////////////////////////////////////////////////////
    wb_write(32'(reg_siz), 32'(siz_16));
    wb_write(32'(reg_stp), 32'(p_one));
    wb_write(32'(reg_off), 32'(off_2));
    wb_write(32'(reg_mul), 32'(mul_one));
    wb_write(32'(reg_sum), 32'(bst_sum));
    wb_write(32'(reg_bdl), 32'd3);
    wb_write(32'(reg_bln), 32'd2);
    wb_write(32'(reg_bnm), 32'd1);
    wb_write(32'(reg_trg), 32'h4);  // only bit 2 armed
    wb_write(32'(reg_bst), 32'h1);
    t0 = trg_cnt;
    trg_ext = 4'b0001;
    @(negedge bus);
    trg_ext = '0;
    expect_quiet(10, "out_valid after masked trigger");
    check_word("trg_out after masked trigger", trg_cnt - t0, 0);
    s0 = stp_cnt;
    trg_ext = 4'b0100;
    @(negedge bus);
    trg_ext = '0;
    collect(n_bst, 1'b0);
    expect_quiet(8, "out_valid after the last burst");
    check_word("irq_stp pulses", stp_cnt - s0, 1);
    wb_read(32'(reg_ctl), w);
    check_word("reg_ctl after bursts", w, 32'h2);  // stopped only
    i = 0;
    for (per = 0; per < 2; per++) begin
      p = off_2;
      for (j = 0; j < 6; j++) begin
        if (j < 4) begin
          exp_d = lin_ref(tbl[p[cw-1:cwf]], mul_one, bst_sum);
          p = ptr_step(p, p_one, siz_16);
        end else begin
          exp_d = bst_sum;  // gap sample is zero plus offset
        end
        check_sample($sformatf("burst out_data %0d", i), got_d[i], exp_d);
        check_bit($sformatf("burst out_last %0d", i), got_l[i], j == 5);
        i++;
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

  // watchdog
  initial begin
    #(wd_cycles * 20);
    abort("watchdog expired before the test sequence finished");
  end

endmodule

// ==== verification/asg_checker.sv ====
//////////////////////////////////////////////////////////////////////
// protocol checker for the signal generator
// wishbone ack rules and sample stream stability
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_checker
  import asg_pkg::*;
(
  input logic    bus,
  input logic    rst_n,
  input logic    cyc,
  input logic    stb,
  input logic    ack,
  input logic    out_valid,
  input logic    out_ready,
  input logic    out_last,
  input sample_t out_data
);

  // ack only answers a live strobe
  ack_in_cycle: assert property (@(posedge bus) disable iff (!rst_n)
    ack |-> (cyc && stb))
    else $error("ack high outside of a bus cycle");

  // classic ack, single cycle
  ack_single: assert property (@(posedge bus) disable iff (!rst_n)
    ack |=> !ack)
    else $error("ack high for two cycles running");

  // stalled sample must not move
  stream_hold: assert property (@(posedge bus) disable iff (!rst_n)
    (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_last)))
    else $error("out_data or out_last changed while stalled");

  valid_known: assert property (@(posedge bus) disable iff (!rst_n)
    !$isunknown(out_valid))
    else $error("out_valid unknown after reset");

endmodule

bind asg_top asg_checker asg_checker_inst (
  .bus       (bus),
  .rst_n     (rst_n),
  .cyc       (cyc),
  .stb       (stb),
  .ack       (ack),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_last  (out_last),
  .out_data  (out_data)
);

// ==== src/asg_top.sv ====
//////////////////////////////////////////////////////////////////////
// arbitrary signal generator top
// register block, waveform table, core and gain/offset stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_top
  import asg_pkg::*;
(
  input  logic           bus,
  input  logic           rst_n,
  // wishbone classic slave
  input  logic           cyc,
  input  logic           stb,
  input  logic           we,
  input  logic [bw-1:0]  adr,
  input  logic [bw-1:0]  dat_w,
  output logic [bw-1:0]  dat_r,
  output logic           ack,
  // triggers and interrupts
  input  logic [tn-1:0]  trg_ext,
  output logic           trg_swo,
  output logic           trg_out,
  output logic           irq_trg,
  output logic           irq_stp,
  // sample stream
  output logic           out_valid,
  output sample_t        out_data,
  output logic           out_last,
  input  logic           out_ready
);

  logic           buf_we;
  logic [cwm-1:0] buf_addr;
  sample_t        buf_wdata, buf_rdata;
  logic           ctl_rst;
  logic [tn-1:0]  cfg_trg;
  ptr_t           cfg_siz, cfg_off, cfg_stp;
  logic           cfg_ben, cfg_inf;
  logic [cwm-1:0] cfg_bdl;
  logic [cwl-1:0] cfg_bln, sts_bln;
  logic [cwn-1:0] cfg_bnm, sts_bnm;
  sample_t        cfg_mul, cfg_sum;
  logic           sts_run;
  // generator path
  logic           adv, rd_en, gen_valid, gen_zero, gen_last;
  logic [cwm-1:0] rd_addr;
  sample_t        rd_data, sample;

  asg_regs asg_regs_inst (
    .bus, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .buf_we, .buf_addr, .buf_wdata, .buf_rdata,
    .ctl_rst, .trg_swo,
    .cfg_trg, .cfg_siz, .cfg_off, .cfg_stp, .cfg_ben, .cfg_inf,
    .cfg_bdl, .cfg_bln, .cfg_bnm, .cfg_mul, .cfg_sum,
    .sts_run, .sts_bln, .sts_bnm
  );

  asg_buffer asg_buffer_inst (
    .bus, .we (buf_we), .addr (buf_addr), .wdata (buf_wdata), .rdata (buf_rdata),
    .rd_en, .rd_addr, .rd_data
  );

  asg_core asg_core_inst (
    .bus, .rst_n, .adv, .ctl_rst, .trg_swo, .trg_ext,
    .cfg_trg, .cfg_siz, .cfg_off, .cfg_stp, .cfg_ben, .cfg_inf,
    .cfg_bdl, .cfg_bln, .cfg_bnm,
    .rd_data, .rd_en, .rd_addr,
    .gen_valid, .gen_zero, .gen_last, .sample,
    .trg_out, .irq_trg, .irq_stp, .sts_run, .sts_bln, .sts_bnm
  );

  asg_linear asg_linear_inst (
    .bus, .rst_n, .gen_valid, .gen_last, .sample, .cfg_mul, .cfg_sum,
    .out_ready, .adv, .out_valid, .out_last, .out_data
  );

endmodule

// ==== src/asg_linear.sv ====
//////////////////////////////////////////////////////////////////////
// gain and offset stage
// k*x + o with saturation, last register before the stream output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_linear
  import asg_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     gen_valid,
  input  logic     gen_last,
  input  sample_t  sample,
  input  sample_t  cfg_mul,
  input  sample_t  cfg_sum,
  input  logic     out_ready,
  output logic     adv,
  output logic     out_valid,
  output logic     out_last,
  output sample_t  out_data
);

  logic signed [2*dw-1:0]         prod;     // full product
  logic signed [2*dw-mul_shift-1:0] shifted;  // drop gain fraction
  logic signed [2*dw-mul_shift:0]   res;      // plus offset, one guard bit
  sample_t                          sat;

  assign adv = out_ready | ~out_valid;  // whole pipeline moves on this

  assign prod    = sample * cfg_mul;
  assign shifted = prod[2*dw-1:mul_shift];  // arithmetic >>> 12
  assign res     = shifted + cfg_sum;

  // clip to -8192..8191 when the top bits disagree
  assign sat = (res[2*dw-mul_shift:dw-1] == '0 || res[2*dw-mul_shift:dw-1] == '1) ?
               res[dw-1:0] :
               (res[2*dw-mul_shift] ? {1'b1, {(dw-1){1'b0}}} : {1'b0, {(dw-1){1'b1}}});

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (adv) begin
      out_valid <= gen_valid;
      out_last  <= gen_valid & gen_last;
    end
  end

  always_ff @(posedge bus) begin
    if (adv) out_data <= sat;
  end

endmodule

// ==== src/asg_core.sv ====
//////////////////////////////////////////////////////////////////////
// generator core
// trigger select, fixed point table pointer, burst sequencing,
// trigger and stop interrupts
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_core
  import asg_pkg::*;
(
  input  logic            bus,
  input  logic            rst_n,
  input  logic            adv,       // pipeline enable
  input  logic            ctl_rst,
  input  logic            trg_swo,
  input  logic [tn-1:0]   trg_ext,
  input  logic [tn-1:0]   cfg_trg,
  input  ptr_t            cfg_siz,
  input  ptr_t            cfg_off,
  input  ptr_t            cfg_stp,
  input  logic            cfg_ben,
  input  logic            cfg_inf,
  input  logic [cwm-1:0]  cfg_bdl,
  input  logic [cwl-1:0]  cfg_bln,
  input  logic [cwn-1:0]  cfg_bnm,
  input  sample_t         rd_data,
  output logic            rd_en,
  output logic [cwm-1:0]  rd_addr,
  output logic            gen_valid,
  output logic            gen_zero,
  output logic            gen_last,
  output sample_t         sample,
  output logic            trg_out,
  output logic            irq_trg,
  output logic            irq_stp,
  output logic            sts_run,
  output logic [cwl-1:0]  sts_bln,
  output logic [cwn-1:0]  sts_bnm
);

  logic [tn-1:0] trg_ext_q;  // edge detect
  logic          start;
  ptr_t          ptr;
  logic [cw:0]   ptr_sum;    // one spare bit for the carry
  logic          wrap;
  ptr_t          ptr_nxt;
  logic [cwl:0]  per_len;    // bdl + bln, last index of a period
  logic          per_end;
  logic          idle;
  logic          last_smp;
  logic          fin;

  // sw trigger or masked rising edge, only while stopped
  assign start = (trg_swo | (|(trg_ext & ~trg_ext_q & cfg_trg))) & ~sts_run;

  // pointer step with a single wrap subtraction
  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_stp};
  assign wrap    = ptr_sum >= {1'b0, cfg_siz};
  assign ptr_nxt = wrap ? ptr_t'(ptr_sum - {1'b0, cfg_siz}) : ptr_t'(ptr_sum);

  ////////////////////////////////////////////////////////////////////
  // burst bookkeeping
  ////////////////////////////////////////////////////////////////////

  assign per_len  = {{(cwl+1-cwm){1'b0}}, cfg_bdl} + {1'b0, cfg_bln};
  assign per_end  = {1'b0, sts_bln} == per_len;
  assign idle     = cfg_ben & (sts_bln > {{(cwl-cwm){1'b0}}, cfg_bdl});  // gap samples
  assign last_smp = cfg_ben ? per_end : wrap;  // continuous: table wrap
  assign fin      = cfg_ben & per_end & ~cfg_inf & (sts_bnm == cfg_bnm);

  // table read, skipped during the gap
  assign rd_en   = adv & sts_run & ~idle;
  assign rd_addr = ptr[cw-1:cwf];  // integer part
  assign sample  = gen_zero ? '0 : rd_data;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      trg_ext_q <= '0;
      sts_run   <= 1'b0;
      ptr       <= '0;
      sts_bln   <= '0;
      sts_bnm   <= '0;
      gen_valid <= 1'b0;
      gen_zero  <= 1'b0;
      gen_last  <= 1'b0;
      trg_out   <= 1'b0;
      irq_trg   <= 1'b0;
      irq_stp   <= 1'b0;
    end else begin
      trg_ext_q <= trg_ext;
      trg_out   <= start & ~ctl_rst;
      irq_trg   <= start & ~ctl_rst;
      irq_stp   <= 1'b0;
      // stage beside the table read
      if (adv) begin
        gen_valid <= sts_run;
        gen_zero  <= idle;
        gen_last  <= sts_run & last_smp;
      end
      if (ctl_rst) begin
        sts_run   <= 1'b0;
        ptr       <= cfg_off;
        sts_bln   <= '0;
        sts_bnm   <= '0;
        gen_valid <= 1'b0;  // drop the pending sample
      end else if (start) begin
        sts_run <= 1'b1;
        ptr     <= cfg_off;
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (adv && sts_run) begin
        if (cfg_ben && per_end) begin
          sts_bln <= '0;
          ptr     <= cfg_off;  // each burst restarts at the phase
          if (fin) begin
            sts_run <= 1'b0;
            irq_stp <= 1'b1;
          end else begin
            sts_bnm <= sts_bnm + 1'b1;
          end
        end else begin
          if (cfg_ben) sts_bln <= sts_bln + 1'b1;
          if (!idle) ptr <= ptr_nxt;
        end
      end
    end
  end

endmodule

// ==== src/asg_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// waveform table
// simple dual port ram, bus write/read port plus a
// generator read port that holds its data while stalled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_buffer
  import asg_pkg::*;
(
  input  logic            bus,
  // bus port
  input  logic            we,
  input  logic [cwm-1:0]  addr,
  input  sample_t         wdata,
  output sample_t         rdata,
  // generator port
  input  logic            rd_en,
  input  logic [cwm-1:0]  rd_addr,
  output sample_t         rd_data
);

  sample_t mem [0:(1<<cwm)-1];  // 1024 samples

  // bus side, read data one cycle later
  always_ff @(posedge bus) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  // generator side
  always_ff @(posedge bus) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // held when rd_en low, pipeline stall
    end
  end

endmodule

// ==== src/asg_regs.sv ====
//////////////////////////////////////////////////////////////////////
// generator register block
// wishbone classic slave, config and status registers,
// table access forwarding and control pulses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module asg_regs
  import asg_pkg::*;
(
  input  logic            bus,
  input  logic            rst_n,
  // wishbone classic slave
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  logic [bw-1:0]   adr,
  input  logic [bw-1:0]   dat_w,
  output logic [bw-1:0]   dat_r,
  output logic            ack,
  // table bus port
  output logic            buf_we,
  output logic [cwm-1:0]  buf_addr,
  output sample_t         buf_wdata,
  input  sample_t         buf_rdata,
  // control pulses
  output logic            ctl_rst,
  output logic            trg_swo,
  // configuration
  output logic [tn-1:0]   cfg_trg,
  output ptr_t            cfg_siz,
  output ptr_t            cfg_off,
  output ptr_t            cfg_stp,
  output logic            cfg_ben,
  output logic            cfg_inf,
  output logic [cwm-1:0]  cfg_bdl,
  output logic [cwl-1:0]  cfg_bln,
  output logic [cwn-1:0]  cfg_bnm,
  output sample_t         cfg_mul,
  output sample_t         cfg_sum,
  // status
  input  logic            sts_run,
  input  logic [cwl-1:0]  sts_bln,
  input  logic [cwn-1:0]  sts_bnm
);

  logic                   xfer;       // strobe cycle, before ack
  logic                   wr_reg;     // register region write
  logic [buf_sel_bit-1:0] roff;       // register byte offset
  logic [bw-1:0]          reg_rdata;
  logic                   buf_sel_q;  // last access went to the table

  assign xfer   = cyc & stb & ~ack;
  assign roff   = adr[buf_sel_bit-1:0];
  assign wr_reg = xfer & we & ~adr[buf_sel_bit];

  // table port, addressed by word
  assign buf_we    = xfer & we & adr[buf_sel_bit];
  assign buf_addr  = adr[cwm+1:2];
  assign buf_wdata = dat_w[dw-1:0];

  // single cycle pulses on the write strobe
  assign ctl_rst = wr_reg & (roff == reg_ctl) & dat_w[0];
  assign trg_swo = wr_reg & (roff == reg_ctl) & dat_w[1];

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      ack       <= 1'b0;
      buf_sel_q <= 1'b0;
    end else begin
      ack <= xfer;  // one cycle, always the next
      if (xfer) buf_sel_q <= adr[buf_sel_bit];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      cfg_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_stp <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bln <= '0;
      cfg_bnm <= '0;
      cfg_mul <= mul_one;  // unity gain out of reset
      cfg_sum <= '0;
    end else if (wr_reg) begin
      case (roff)
        reg_trg: cfg_trg <= dat_w[tn-1:0];
        reg_siz: cfg_siz <= dat_w[cw-1:0];
        reg_off: cfg_off <= dat_w[cw-1:0];
        reg_stp: cfg_stp <= dat_w[cw-1:0];
        reg_bst: begin
          cfg_ben <= dat_w[0];
          cfg_inf <= dat_w[1];
        end
        reg_bdl: cfg_bdl <= dat_w[cwm-1:0];
        reg_bln: cfg_bln <= dat_w[cwl-1:0];
        reg_bnm: cfg_bnm <= dat_w[cwn-1:0];
        reg_mul: cfg_mul <= dat_w[dw-1:0];
        reg_sum: cfg_sum <= dat_w[dw-1:0];
        default: ;  // unmapped, dropped
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (xfer) begin
      case (roff)
        reg_ctl:     reg_rdata <= {{(bw-2){1'b0}}, ~sts_run, sts_run};
        reg_trg:     reg_rdata <= {{(bw-tn){1'b0}}, cfg_trg};
        reg_siz:     reg_rdata <= {{(bw-cw){1'b0}}, cfg_siz};
        reg_off:     reg_rdata <= {{(bw-cw){1'b0}}, cfg_off};
        reg_stp:     reg_rdata <= {{(bw-cw){1'b0}}, cfg_stp};
        reg_bst:     reg_rdata <= {{(bw-2){1'b0}}, cfg_inf, cfg_ben};
        reg_bdl:     reg_rdata <= {{(bw-cwm){1'b0}}, cfg_bdl};
        reg_bln:     reg_rdata <= cfg_bln;
        reg_bnm:     reg_rdata <= {{(bw-cwn){1'b0}}, cfg_bnm};
        reg_sts_bln: reg_rdata <= sts_bln;
        reg_sts_bnm: reg_rdata <= {{(bw-cwn){1'b0}}, sts_bnm};
        reg_mul:     reg_rdata <= {{(bw-dw){1'b0}}, cfg_mul};  // masked, not sign extended
        reg_sum:     reg_rdata <= {{(bw-dw){1'b0}}, cfg_sum};
        default:     reg_rdata <= '0;
      endcase
    end
  end

  // table data arrives in the ack cycle, sign extended
  assign dat_r = buf_sel_q ? {{(bw-dw){buf_rdata[dw-1]}}, buf_rdata} : reg_rdata;

endmodule

// ==== src/asg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// arbitrary signal generator, shared definitions
// sample and pointer types, widths, register map
//////////////////////////////////////////////////////////////////////
package asg_pkg;

  localparam int unsigned dw  = 14;       // sample width
  localparam int unsigned cwm = 10;       // pointer integer bits, 1024 entry table
  localparam int unsigned cwf = 16;       // pointer fraction bits
  localparam int unsigned cw  = cwm + cwf;
  localparam int unsigned cwl = 32;       // burst idle length counter
  localparam int unsigned cwn = 16;       // burst repetition counter
  localparam int unsigned tn  = 4;        // external triggers
  localparam int unsigned bw  = 32;       // wishbone data width

  typedef logic signed [dw-1:0] sample_t;
  typedef logic        [cw-1:0] ptr_t;    // size, offset, step, read pointer

  // byte address bit 12 picks the table, below is registers
  localparam int unsigned buf_sel_bit = 12;

  localparam logic [buf_sel_bit-1:0] reg_ctl     = 'h000;  // reset, sw trigger
  localparam logic [buf_sel_bit-1:0] reg_trg     = 'h004;  // trigger mask
  localparam logic [buf_sel_bit-1:0] reg_siz     = 'h010;
  localparam logic [buf_sel_bit-1:0] reg_off     = 'h014;  // phase
  localparam logic [buf_sel_bit-1:0] reg_stp     = 'h018;  // frequency
  localparam logic [buf_sel_bit-1:0] reg_bst     = 'h020;  // burst en, infinite
  localparam logic [buf_sel_bit-1:0] reg_bdl     = 'h024;
  localparam logic [buf_sel_bit-1:0] reg_bln     = 'h028;
  localparam logic [buf_sel_bit-1:0] reg_bnm     = 'h02c;
  localparam logic [buf_sel_bit-1:0] reg_sts_bln = 'h030;  // read only
  localparam logic [buf_sel_bit-1:0] reg_sts_bnm = 'h034;  // read only
  localparam logic [buf_sel_bit-1:0] reg_mul     = 'h038;  // gain, 1.0 = 0x1000
  localparam logic [buf_sel_bit-1:0] reg_sum     = 'h03c;  // offset

  localparam sample_t     mul_one   = 14'sh1000;  // unity gain
  localparam int unsigned mul_shift = 12;         // gain fraction bits

endpackage
